// File: div_macros.svh
// ----------------------------------------
// Approximate FP32 divider constants
// Field widths, bias and table sizing
// ----------------------------------------
`ifndef DIV_MACROS_SVH
`define DIV_MACROS_SVH

// Single-precision field layout
// Stored fraction, hidden bit excluded
`define FRAC_BITS 23

// Biased exponent field
`define EXP_BITS 8

// Exponent bias for single precision
`define FP_BIAS 127

// Reciprocal table
// Address comes from the top fraction bits of t
// 256 entries over [1, 2)
`define RECIP_ADDR_BITS 8

// Special result words
// Positive quiet NaN, exponent all ones and fraction MSB set
`define QNAN_BITS 32'h7fc0_0000

`endif

// File: div_pkg.sv
// ----------------------------------------
// Shared types for the approximate divider
// ----------------------------------------
`include "div_macros.svh"

package div_pkg;

  // Raw fraction field of an operand
  // Read as a value in [0, 1)
  typedef logic [`FRAC_BITS-1:0] frac_t;

  // Signed fixed-point mantissa
  // Sign guard bit, one integer bit, then the fraction bits
  // 1.0 sits at bit FRAC_BITS
  typedef logic signed [`FRAC_BITS+1:0] mant_t;

  // ------------------------------------
  // Compensation plane coefficients
  // ------------------------------------
  // Every coefficient is +/- 2^-sh
  // neg flag selects the minus sign
  typedef struct packed {
    logic       a_neg;
    logic [5:0] a_sh;
    logic       b_neg;
    logic [5:0] b_sh;
    logic       c_neg;
    logic [5:0] c_sh;
    // Drops the y term entirely
    logic       b_is_zero;
  } coeff_t;

  // ------------------------------------
  // Operand classes
  // ------------------------------------
  // Subnormals fold into OP_ZERO
  typedef enum logic [1:0] {
    OP_NORMAL = 2'd0,
    OP_ZERO   = 2'd1,
    OP_INF    = 2'd2,
    OP_NAN    = 2'd3
  } op_class_t;

endpackage

// File: recip_lut.sv
// ----------------------------------------
// Reciprocal ROM over [1, 2)
// Output 1/t in Q1 format, rounded to nearest
// ----------------------------------------
`timescale 1ns/1ps
`include "div_macros.svh"

module recip_lut #(
  parameter int FRAC_BITS = `FRAC_BITS,
  parameter int ADDR_BITS = `RECIP_ADDR_BITS
) (
  input  logic [ADDR_BITS-1:0] addr,
  output logic [FRAC_BITS:0]   recip
);

  localparam int DEPTH = 1 << ADDR_BITS;

  // Entry i holds round(2^(F+A) / (2^A + i))
  // Entry 0 is exactly 1.0
  function automatic logic [FRAC_BITS:0] entry_val(input int unsigned i);
    longint unsigned num;
    longint unsigned den;
    longint unsigned quo;
    num = 64'd1 << (FRAC_BITS + ADDR_BITS);
    den = (64'd1 << ADDR_BITS) + 64'(i);
    // Half the divisor added first for round to nearest
    quo = (num + (den >> 1)) / den;
    return quo[FRAC_BITS:0];
  endfunction

  logic [FRAC_BITS:0] rom [DEPTH];

  // Table filled at elaboration
  for (genvar k = 0; k < DEPTH; k++) begin : g_rom
    localparam logic [FRAC_BITS:0] VAL = entry_val(k);
    assign rom[k] = VAL;
  end

  // Plain combinational read
  assign recip = rom[addr];

endmodule

// File: mant_approx.sv
// ----------------------------------------
// Two-region mantissa estimate
// Linear when x > y, else reciprocal of 1 + y - x
// ----------------------------------------
`timescale 1ns/1ps
`include "div_macros.svh"

module mant_approx
  import div_pkg::*;
(
  input  frac_t x,
  input  frac_t y,
  output mant_t m_approx
);

  localparam int FB = `FRAC_BITS;
  localparam int AB = `RECIP_ADDR_BITS;

  // 1.0 in mantissa format
  localparam mant_t ONE = mant_t'(1 << FB);

  logic                x_gt_y;
  mant_t               m_lin;
  mant_t               t;
  logic [AB-1:0]       recip_addr;
  logic [FB:0]         recip;

  assign x_gt_y = (x > y);

  // Linear region, result in (1, 2)
  assign m_lin = ONE + mant_t'(x) - mant_t'(y);

  // t in [1, 2) whenever x <= y
  assign t = ONE + mant_t'(y) - mant_t'(x);

  // Top fraction bits of t index the table
  // Garbage for x > y but then unused
  assign recip_addr = t[FB-1 -: AB];

  recip_lut #(
    .FRAC_BITS (FB),
    .ADDR_BITS (AB)
  ) recip_lut_i (
    .addr  (recip_addr),
    .recip (recip)
  );

  // Region select
  // Reciprocal is unsigned, so zero extend
  always_comb begin
    if (x_gt_y) begin
      m_approx = m_lin;
    end else begin
      m_approx = mant_t'(recip);
    end
  end

endmodule

// File: plane_comp.sv
// ----------------------------------------
// First-level compensation plane
// p = A*x + B*y + C over four regions
// ----------------------------------------
`timescale 1ns/1ps
`include "div_macros.svh"

module plane_comp
  import div_pkg::*;
#(
  parameter int LEVEL = 1
) (
  input  frac_t x,
  input  frac_t y,
  output mant_t p
);

  localparam int FB = `FRAC_BITS;
  localparam mant_t ONE = mant_t'(1 << FB);

  // Only level 0 and the four-plane level exist
  if (LEVEL != 0 && LEVEL != 1) begin : g_bad_level
    $error("plane_comp: LEVEL must be 0 or 1");
  end

  // +/- v * 2^-sh, v read as a fraction
  function automatic mant_t frac_term(
    input frac_t      v,
    input logic       neg,
    input logic [5:0] sh
  );
    mant_t mag;
    mag = mant_t'(v) >>> sh;
    return neg ? -mag : mag;
  endfunction

  // Constant +/- 2^-sh
  function automatic mant_t const_term(
    input logic       neg,
    input logic [5:0] sh
  );
    mant_t mag;
    mag = ONE >>> sh;
    return neg ? -mag : mag;
  endfunction

  // --------------------------------------
  // Region select
  // --------------------------------------
  // One extra bit so the doubled fractions fit
  logic [FB:0] x_w;
  logic [FB:0] y_w;
  logic [FB:0] x_dbl;
  logic [FB:0] y_dbl;
  logic [1:0]  region;

  assign x_w   = {1'b0, x};
  assign y_w   = {1'b0, y};
  assign x_dbl = {x, 1'b0};
  assign y_dbl = {y, 1'b0};

  // Boundaries at y = x/2, y = x and y = 2x
  always_comb begin
    if (y_dbl < x_w) begin
      region = 2'd0;
    end else if (y < x) begin
      region = 2'd1;
    end else if (y_w < x_dbl) begin
      region = 2'd2;
    end else begin
      region = 2'd3;
    end
  end

  // --------------------------------------
  // Coefficients per region
  // --------------------------------------
  coeff_t coeff;

  always_comb begin
    coeff = '0;
    unique case (region)
      2'd0: begin
        // A -1/16, B -1/4, C +1/64
        coeff.a_neg = 1'b1;
        coeff.a_sh  = 6'd4;
        coeff.b_neg = 1'b1;
        coeff.b_sh  = 6'd2;
        coeff.c_neg = 1'b0;
        coeff.c_sh  = 6'd6;
      end
      2'd1: begin
        // A -1/4, B +1/4, C -1/128
        coeff.a_neg = 1'b1;
        coeff.a_sh  = 6'd2;
        coeff.b_neg = 1'b0;
        coeff.b_sh  = 6'd2;
        coeff.c_neg = 1'b1;
        coeff.c_sh  = 6'd7;
      end
      2'd2: begin
        // A -1/16, B +1/8, C -1/128
        coeff.a_neg = 1'b1;
        coeff.a_sh  = 6'd4;
        coeff.b_neg = 1'b0;
        coeff.b_sh  = 6'd3;
        coeff.c_neg = 1'b1;
        coeff.c_sh  = 6'd7;
      end
      default: begin
        // A +1/8, B +1/32, C -1/128
        coeff.a_neg = 1'b0;
        coeff.a_sh  = 6'd3;
        coeff.b_neg = 1'b0;
        coeff.b_sh  = 6'd5;
        coeff.c_neg = 1'b1;
        coeff.c_sh  = 6'd7;
      end
    endcase
  end

  // --------------------------------------
  // Plane value
  // --------------------------------------
  mant_t term_a;
  mant_t term_b;
  mant_t term_c;
  mant_t p_plane;

  assign term_a  = frac_term(x, coeff.a_neg, coeff.a_sh);
  assign term_b  = frac_term(y, coeff.b_neg, coeff.b_sh);
  assign term_c  = const_term(coeff.c_neg, coeff.c_sh);
  assign p_plane = term_a + term_b + term_c;

  // Level 0 leaves the estimate untouched
  assign p = (LEVEL == 0) ? '0 : p_plane;

endmodule

// File: result_pack.sv
// ----------------------------------------
// Normalize, form exponent, clamp, special cases
// Registers the packed FP32 quotient
// ----------------------------------------
`timescale 1ns/1ps
`include "div_macros.svh"

module result_pack
  import div_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  mant_t       m_ref,
  output logic [31:0] q
);

  localparam int FB = `FRAC_BITS;
  localparam int EB = `EXP_BITS;

  // Normalization thresholds, 1.0 and 2.0
  localparam logic [FB+1:0] ONE_Q = (FB+2)'(1) << FB;
  localparam logic [FB+1:0] TWO_Q = (FB+2)'(2) << FB;

  // Subnormals count as zero
  function automatic op_class_t classify(input logic [31:0] v);
    logic [EB-1:0] e;
    logic [FB-1:0] f;
    e = v[30 -: EB];
    f = v[FB-1:0];
    if (e == '0) begin
      return OP_ZERO;
    end
    if (e == '1) begin
      if (f == '0) begin
        return OP_INF;
      end
      return OP_NAN;
    end
    return OP_NORMAL;
  endfunction

  // --------------------------------------
  // Operand fields
  // --------------------------------------
  logic          so;
  logic [EB-1:0] ea;
  logic [EB-1:0] eb;
  op_class_t     cls_a;
  op_class_t     cls_b;

  assign so    = a[31] ^ b[31];
  assign ea    = a[30 -: EB];
  assign eb    = b[30 -: EB];
  assign cls_a = classify(a);
  assign cls_b = classify(b);

  // --------------------------------------
  // One-bit normalization and exponent
  // --------------------------------------
  logic [FB+1:0]      mant_pos;
  logic [FB+1:0]      mant_norm;
  logic signed [1:0]  exp_adj;
  logic signed [10:0] exp_q;

  always_comb begin
    // Negative estimate clamps to zero
    mant_pos  = m_ref[FB+1] ? '0 : m_ref;
    mant_norm = mant_pos;
    exp_adj   = 2'sd0;
    if (mant_pos < ONE_Q) begin
      mant_norm = mant_pos << 1;
      exp_adj   = -2'sd1;
    end else if (mant_pos >= TWO_Q) begin
      mant_norm = mant_pos >> 1;
      exp_adj   = 2'sd1;
    end
    // Biases of ea and eb cancel, add one back
    exp_q = $signed({3'b000, ea}) - $signed({3'b000, eb}) + exp_adj
          + 11'sd`FP_BIAS;
  end

  // --------------------------------------
  // Result select
  // --------------------------------------
  logic [31:0] inf_word;
  logic [31:0] zero_word;
  logic [31:0] q_norm;
  logic [31:0] q_next;

  assign inf_word  = {so, {EB{1'b1}}, {FB{1'b0}}};
  assign zero_word = {so, {(EB+FB){1'b0}}};

  // Overflow to infinity, underflow to zero
  // Fraction truncates, no rounding
  always_comb begin
    if (exp_q >= 11'sd255) begin
      q_norm = inf_word;
    end else if (exp_q <= 11'sd0) begin
      q_norm = zero_word;
    end else begin
      q_norm = {so, exp_q[EB-1:0], mant_norm[FB-1:0]};
    end
  end

  // Specials in priority order
  always_comb begin
    if (cls_a == OP_NAN || cls_b == OP_NAN) begin
      q_next = `QNAN_BITS;
    end else if (cls_a == OP_INF && cls_b == OP_INF) begin
      q_next = `QNAN_BITS;
    end else if (cls_a == OP_INF) begin
      q_next = inf_word;
    end else if (cls_b == OP_INF) begin
      q_next = zero_word;
    end else if (cls_b == OP_ZERO) begin
      // Divide by zero
      q_next = inf_word;
    end else if (cls_a == OP_ZERO) begin
      q_next = zero_word;
    end else begin
      q_next = q_norm;
    end
  end

  // Second pipeline stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      q <= '0;
    end else begin
      q <= q_next;
    end
  end

endmodule

// File: approx_div_fp32.sv
// ----------------------------------------
// Approximate FP32 divider, two-stage pipeline
// Linearized mantissa plus plane compensation
// ----------------------------------------
`timescale 1ns/1ps
`include "div_macros.svh"

module approx_div_fp32
  import div_pkg::*;
#(
  parameter int LEVEL = 1
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [31:0] q
);

  // Fractions of dividend and divisor
  frac_t x;
  frac_t y;

  assign x = a[`FRAC_BITS-1:0];
  assign y = b[`FRAC_BITS-1:0];

  mant_t m_approx;
  mant_t p;
  mant_t m_sum;

  mant_approx mant_approx_i (
    .x        (x),
    .y        (y),
    .m_approx (m_approx)
  );

  plane_comp #(
    .LEVEL (LEVEL)
  ) plane_comp_i (
    .x (x),
    .y (y),
    .p (p)
  );

  // Refined mantissa
  assign m_sum = m_approx + p;

  // --------------------------------------
  // Stage one
  // --------------------------------------
  logic [31:0] a_s1;
  logic [31:0] b_s1;
  mant_t       m_s1;

  // Operands ride along for classification and exponent
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      a_s1 <= '0;
      b_s1 <= '0;
      m_s1 <= '0;
    end else begin
      a_s1 <= a;
      b_s1 <= b;
      m_s1 <= m_sum;
    end
  end

  // Stage two, registers q
  result_pack result_pack_i (
    .clk   (clk),
    .rst_n (rst_n),
    .a     (a_s1),
    .b     (b_s1),
    .m_ref (m_s1),
    .q     (q)
  );

endmodule

// File: tb_approx_div_props.sv
// ----------------------------------------
// Assertions on the output stage
// Reset, NaN and divide-by-zero results
// ----------------------------------------
`timescale 1ns/1ps
`include "div_macros.svh"

module tb_approx_div_props (
  input logic        clk,
  input logic        rst_n,
  input logic [31:0] a,
  input logic [31:0] b,
  input logic [31:0] q
);

  logic a_nan;
  logic b_nan;
  logic b_zero;

  // Operand classes from the raw fields
  assign a_nan  = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
  assign b_nan  = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
  assign b_zero = (b[30:23] == 8'h00);

  reset_clears_q: assert property (@(posedge clk) !rst_n |=> (q == 32'h0))
    else $error("q not zero one cycle after reset");

  nan_gives_qnan: assert property (@(posedge clk)
    (rst_n && (a_nan || b_nan)) |=> (q == `QNAN_BITS))
    else $error("NaN operand did not give the quiet NaN");

  // NaN dividend takes the NaN rule first
  zero_divisor_inf: assert property (@(posedge clk)
    (rst_n && b_zero && !a_nan) |=> (q[30:23] == 8'hff))
    else $error("zero divisor did not give an infinite exponent");

endmodule

bind result_pack tb_approx_div_props props_i (
  .clk   (clk),
  .rst_n (rst_n),
  .a     (a),
  .b     (b),
  .q     (q)
);

// File: tb_approx_div.sv
// ----------------------------------------
// Testbench for the approximate FP32 divider
// Directed tests against a bit-exact model
// ----------------------------------------
`timescale 1ns/1ps
`include "div_macros.svh"

module tb_approx_div
  import div_pkg::*;
();

  localparam int     MAX_CYCLES = 2000;
  localparam longint MANT_ONE   = longint'(1) << `FRAC_BITS;
  localparam int     IDX_SHIFT  = `FRAC_BITS - `RECIP_ADDR_BITS;

  logic        clk;
  logic        rst_n;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] q;
  int          edge_cnt;
  int          word_errs;
  int          class_errs;
  // Pending results, oldest first
  logic [31:0] expect_q[$];
  string       name_q[$];
  int          due_q[$];

  approx_div_fp32 #(.LEVEL(1)) dut_i (
    .clk   (clk),
    .rst_n (rst_n),
    .a     (a),
    .b     (b),
    .q     (q)
  );

  always #20 clk = ~clk;

  // Edge counter doubles as the run limit
  always @(posedge clk) begin
    edge_cnt <= edge_cnt + 1;
    if (edge_cnt >= MAX_CYCLES) begin
      $display("Timeout: no end of test after %0d cycles", MAX_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic op_class_t class_of(input logic [31:0] v);
    if (v[30:23] == 8'h00) return OP_ZERO;
    if (v[30:23] != 8'hff) return OP_NORMAL;
    return (v[22:0] == 23'd0) ? OP_INF : OP_NAN;
  endfunction

  // Four-plane correction, terms truncate before the sign
  function automatic longint plane_corr(input longint xf, input longint yf);
    if (2 * yf < xf) return -(xf >>> 4) - (yf >>> 2) + (MANT_ONE >>> 6);
    if (yf < xf) return -(xf >>> 2) + (yf >>> 2) - (MANT_ONE >>> 7);
    if (yf < 2 * xf) return -(xf >>> 4) + (yf >>> 3) - (MANT_ONE >>> 7);
    return (xf >>> 3) + (yf >>> 5) - (MANT_ONE >>> 7);
  endfunction

  function automatic logic [31:0] model_div(input logic [31:0] va, input logic [31:0] vb);
    op_class_t   ca;
    op_class_t   cb;
    logic        s;
    logic [31:0] inf_w;
    logic [31:0] zero_w;
    longint      xf;
    longint      yf;
    longint      den;
    longint      m;
    longint      e;
    ca     = class_of(va);
    cb     = class_of(vb);
    s      = va[31] ^ vb[31];
    inf_w  = {s, 8'hff, 23'd0};
    zero_w = {s, 31'd0};
    if (ca == OP_NAN || cb == OP_NAN) return `QNAN_BITS;
    if (ca == OP_INF && cb == OP_INF) return `QNAN_BITS;
    if (ca == OP_INF) return inf_w;
    if (cb == OP_INF) return zero_w;
    if (cb == OP_ZERO) return inf_w;
    if (ca == OP_ZERO) return zero_w;
    xf = longint'(va[22:0]);
    yf = longint'(vb[22:0]);
    if (xf > yf) begin
      m = MANT_ONE + xf - yf;
    end else begin
      // Table index from the top bits of 1 + y - x
      den = (longint'(1) << `RECIP_ADDR_BITS)
          + (((MANT_ONE + yf - xf) >> IDX_SHIFT) & 255);
      m = ((longint'(1) << (`FRAC_BITS + `RECIP_ADDR_BITS)) + den / 2) / den;
    end
    m = m + plane_corr(xf, yf);
    if (m < 0) m = 0;
    e = longint'(va[30:23]) - longint'(vb[30:23]) + `FP_BIAS;
    if (m < MANT_ONE) begin
      m = m * 2;
      e = e - 1;
    end else if (m >= 2 * MANT_ONE) begin
      m = m / 2;
      e = e + 1;
    end
    if (e >= 255) return inf_w;
    if (e <= 0) return zero_w;
    return {s, e[7:0], m[22:0]};
  endfunction

  // ----------------------------------------
  // Checks and stimulus
  // ----------------------------------------
  task automatic check_word(input string name, input logic [31:0] expv, input logic [31:0] actv);
    if (actv !== expv) begin
      word_errs++;
      $display("Error %s: expected %08h, actual %08h", name, expv, actv);
    end
  endtask

  task automatic check_class(input string name, input op_class_t expv, input op_class_t actv);
    if (actv !== expv) begin
      class_errs++;
      $display("Error %s: expected %s, actual %s", name, expv.name(), actv.name());
    end
  endtask

  // Result due two edges after the sampling edge
  task automatic apply(input string name, input logic [31:0] va, input logic [31:0] vb);
    @(posedge clk);
    a <= va;
    b <= vb;
    expect_q.push_back(model_div(va, vb));
    name_q.push_back(name);
    due_q.push_back(edge_cnt + 3);
  endtask

  always @(negedge clk) begin
    if (due_q.size() > 0 && due_q[0] == edge_cnt) begin
      check_word(name_q[0], expect_q[0], q);
      due_q.delete(0);
      name_q.delete(0);
      expect_q.delete(0);
    end
  end

  task automatic apply_classed(input string name, input logic [31:0] va, input op_class_t ca,
                               input logic [31:0] vb, input op_class_t cb);
    check_class({name, " a"}, ca, class_of(va));
    check_class({name, " b"}, cb, class_of(vb));
    apply(name, va, vb);
  endtask

  function automatic logic [31:0] random_normal();
    logic        s;
    logic [7:0]  e;
    logic [22:0] f;
    s = 1'($urandom);
    // Mid-range exponents keep most quotients normal
    e = 8'(64 + ($urandom % 127));
    f = 23'($urandom);
    return {s, e, f};
  endfunction

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic test_latency();
    apply("latency 6/2", 32'h40c0_0000, 32'h4000_0000);
    apply("latency 1/3", 32'h3f80_0000, 32'h4040_0000);
    apply("latency -10/0.5", 32'hc120_0000, 32'h3f00_0000);
    apply("latency 100/-10", 32'h42c8_0000, 32'hc120_0000);
  endtask

  task automatic test_specials();
    apply_classed("nan dividend", 32'h7fc0_0001, OP_NAN, 32'h3f80_0000, OP_NORMAL);
    apply_classed("nan divisor", 32'h3f80_0000, OP_NORMAL, 32'hff80_0001, OP_NAN);
    apply_classed("zero by nan", 32'h0000_0000, OP_ZERO, 32'h7fc0_0000, OP_NAN);
    apply_classed("inf by inf", 32'h7f80_0000, OP_INF, 32'hff80_0000, OP_INF);
    apply_classed("-inf by num", 32'hff80_0000, OP_INF, 32'h4000_0000, OP_NORMAL);
    apply_classed("inf by -zero", 32'h7f80_0000, OP_INF, 32'h8000_0000, OP_ZERO);
    apply_classed("num by -inf", 32'h4040_0000, OP_NORMAL, 32'hff80_0000, OP_INF);
    apply_classed("-zero by inf", 32'h8000_0000, OP_ZERO, 32'h7f80_0000, OP_INF);
    apply_classed("-num by zero", 32'hc040_0000, OP_NORMAL, 32'h0000_0000, OP_ZERO);
    apply_classed("num by -sub", 32'h3f80_0000, OP_NORMAL, 32'h8000_0001, OP_ZERO);
    apply_classed("zero by zero", 32'h0000_0000, OP_ZERO, 32'h0000_0000, OP_ZERO);
    apply_classed("sub by -num", 32'h0040_0000, OP_ZERO, 32'hc000_0000, OP_NORMAL);
    apply_classed("-zero by -num", 32'h8000_0000, OP_ZERO, 32'hbf80_0000, OP_NORMAL);
  endtask

  task automatic test_branches();
    apply("linear x>y", 32'h3fc0_0000, 32'h3fa0_0000);
    apply("equal fractions", 32'h4049_0fdb, 32'h3f49_0fdb);
    apply("recip x<y", 32'h3f80_0000, 32'h3fc0_0000);
    apply("recip y max", 32'h3fa0_0000, 32'h3f7f_ffff);
    apply("unit by unit", 32'h3f80_0000, 32'h3f80_0000);
  endtask

  task automatic test_regions();
    apply("region 0", 32'h3fe0_0000, 32'h3f90_0000);
    apply("region 1", 32'h3fe0_0000, 32'h3fc0_0000);
    apply("region 1 edge", 32'h3fc0_0000, 32'h3fa0_0000);
    apply("region 2", 32'h3fc0_0000, 32'h3fe0_0000);
    apply("region 3", 32'h3f90_0000, 32'h3fe0_0000);
  endtask

  task automatic test_clamping();
    apply("overflow", 32'h7e80_0000, 32'h0080_0000);
    apply("underflow", 32'h0080_0000, 32'h7e80_0000);
    // Adjustment of -1 pulls 255 back to 254
    apply("adjust below inf", 32'h7f00_0000, 32'h3f40_0000);
    apply("exp hits 255", 32'h7f40_0000, 32'h3f00_0000);
    // Adjustment of -1 pushes 1 down to 0
    apply("adjust to zero", 32'h0080_0000, 32'h3fc0_0000);
    apply("smallest normal", 32'h00c0_0000, 32'h3f80_0000);
  endtask

  task automatic test_random();
    logic [31:0] va;
    logic [31:0] vb;
    for (int i = 0; i < 200; i++) begin
      va = random_normal();
      vb = random_normal();
      apply_classed("random", va, OP_NORMAL, vb, OP_NORMAL);
    end
  endtask

  task automatic drain_results();
    while (due_q.size() > 0) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    a          = '0;
    b          = '0;
    edge_cnt   = 0;
    word_errs  = 0;
    class_errs = 0;
    void'($urandom(32'heedb_1a45));
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_word("reset", 32'h0000_0000, q);
    test_latency();
    test_specials();
    test_branches();
    test_regions();
    test_clamping();
    test_random();
    drain_results();
    $display("Summary: %0d value errors, %0d class errors", word_errs, class_errs);
    if (word_errs + class_errs == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+.
div_pkg.sv
recip_lut.sv
mant_approx.sv
plane_comp.sv
result_pack.sv
approx_div_fp32.sv
tb_approx_div_props.sv
tb_approx_div.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_approx_div
FILELIST  = sources.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
FAIL_MSG  = Errors found
PASS_MSG  = No errors

SOURCES := $(filter %.sv,$(shell cat $(FILELIST)))
HEADERS := div_macros.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
